// File: mem_agen.sv
// Address generation stage
// Forms rs1 + imm, decodes size and lanes, flags misalignment and
// sorts the address into local, bus or unmapped
`timescale 1ns/100ps
`default_nettype none

module mem_agen #(
  parameter int unsigned                    SPAD_WORDS = 256,
  parameter logic [mem_pipe_pkg::XLEN-1:0] BUS_BASE   = 32'h8000_0000,
  parameter logic [mem_pipe_pkg::XLEN-1:0] BUS_SIZE   = 32'h0000_1000
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        dispatch_v_i,
  input  mem_pipe_pkg::mem_dispatch_s dispatch_i,
  input  logic                        stall_i,
  output mem_pipe_pkg::mem_access_s   access_o
);
  import mem_pipe_pkg::*;

  localparam logic [XLEN-1:0] LOCAL_LIMIT = XLEN'(SPAD_WORDS * 4);

  logic [XLEN-1:0] eaddr;
  mem_size_e       size;
  logic            misaligned;
  mem_region_e     region;
  mem_access_s     access_d;
  mem_access_s     access_q;

  assign eaddr = dispatch_i.rs1 + dispatch_i.imm;

  always_comb
  begin
    case (dispatch_i.op)
      e_op_lb, e_op_lbu, e_op_sb: size = e_size_byte;
      e_op_lh, e_op_lhu, e_op_sh: size = e_size_half;
      default:                    size = e_size_word;
    endcase
  end

  assign misaligned = ((size == e_size_half) && eaddr[0])
                   || ((size == e_size_word) && (eaddr[1:0] != 2'b00));

  always_comb
  begin
    if (eaddr < LOCAL_LIMIT)
      region = e_region_local;
    else if ((eaddr >= BUS_BASE) && ((eaddr - BUS_BASE) < BUS_SIZE))
      region = e_region_bus;
    else
      region = e_region_unmapped;
  end

  always_comb
  begin
    access_d        = '0;
    access_d.valid  = 1'b1;
    access_d.op     = dispatch_i.op;
    access_d.size   = size;
    access_d.eaddr  = eaddr;
    access_d.rd     = dispatch_i.rd;
    access_d.region = region;
    // Store data replicated into every lane and the enables pick the live ones
    case (size)
      e_size_byte:
      begin
        access_d.be    = 4'b0001 << eaddr[1:0];
        access_d.wdata = {4{dispatch_i.rs2[7:0]}};
      end
      e_size_half:
      begin
        access_d.be    = 4'b0011 << eaddr[1:0];
        access_d.wdata = {2{dispatch_i.rs2[15:0]}};
      end
      default:
      begin
        access_d.be    = 4'b1111;
        access_d.wdata = dispatch_i.rs2;
      end
    endcase
    if (misaligned)
      access_d.fault = e_fault_misaligned;
    else if (region == e_region_unmapped)
      access_d.fault = e_fault_access;
    else
      access_d.fault = e_fault_none;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      access_q <= '0;
    else if (stall_i)
      access_q <= access_q;
    else if (dispatch_v_i)
      access_q <= access_d;
    else
      access_q <= '0;
  end

  assign access_o = access_q;

endmodule

`default_nettype wire

// File: mem_bus_fsm.sv
// External bus master
// Runs one four-phase req/ack transfer per bus access and holds the
// pipe until its result has gone out
`timescale 1ns/100ps
`default_nettype none

module mem_bus_fsm #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  mem_pipe_pkg::mem_access_s          access_i,
  input  logic                               bus_ack_i,
  input  logic [mem_pipe_pkg::XLEN-1:0]      bus_rdata_i,
  output logic                               bus_req_o,
  output logic [mem_pipe_pkg::XLEN-1:0]      bus_addr_o,
  output logic                               bus_we_o,
  output logic [3:0]                         bus_be_o,
  output logic [mem_pipe_pkg::XLEN-1:0]      bus_wdata_o,
  output logic                               stall_o,
  output logic                               ready_o,
  output logic                               done_o,
  output mem_pipe_pkg::mem_word_u            done_data_o,
  output logic                               done_timeout_o
);
  import mem_pipe_pkg::*;

  typedef enum logic [1:0]
  {
    e_st_idle,
    e_st_request,
    e_st_release,
    e_st_done
  } bus_state_e;

  bus_state_e      state_q;
  bus_state_e      state_d;
  logic            start;
  logic            expired;
  logic            owned_q;
  logic            res_q;
  logic [XLEN-1:0] addr_q;
  logic            we_q;
  logic [3:0]      be_q;
  logic [XLEN-1:0] wdata_q;
  mem_word_u       data_q;
  logic            timeout_q;

  // owned_q masks the access still parked in agen after its transfer
  assign start = (state_q == e_st_idle) && !owned_q && access_i.valid
              && (access_i.region == e_region_bus)
              && (access_i.fault == e_fault_none);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      e_st_idle:
        if (start)
          state_d = e_st_request;
      e_st_request:
        if (bus_ack_i || expired)
          state_d = e_st_release;
      e_st_release:
        if (!bus_ack_i)
          state_d = e_st_done;
      default:
        state_d = e_st_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= e_st_idle;
      owned_q   <= 1'b0;
      res_q     <= 1'b0;
      timeout_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      res_q   <= (state_q == e_st_done);
      if (start)
        owned_q <= 1'b1;
      else if (!stall_o)
        owned_q <= 1'b0;
      if (start)
        timeout_q <= 1'b0;
      else if ((state_q == e_st_request) && !bus_ack_i && expired)
        timeout_q <= 1'b1;
    end
  end

  // Bus payload held stable for the whole request phase
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      addr_q  <= access_i.eaddr;
      we_q    <= op_is_store(access_i.op);
      be_q    <= access_i.be;
      wdata_q <= access_i.wdata;
    end
    if (state_q == e_st_request)
    begin
      if (bus_ack_i)
        data_q <= bus_rdata_i;
      else if (expired)
        data_q <= '0;
    end
  end

  mem_bus_timer #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_timer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .run_i    (bus_req_o && !bus_ack_i),
    .expired_o(expired)
  );

  assign bus_req_o   = (state_q == e_st_request);
  assign bus_addr_o  = addr_q;
  assign bus_we_o    = we_q;
  assign bus_be_o    = be_q;
  assign bus_wdata_o = wdata_q;

  // Held through the result cycle so ready follows result_v by one
  assign stall_o = start || (state_q != e_st_idle) || res_q;
  assign ready_o = !stall_o;

  assign done_o         = (state_q == e_st_done);
  assign done_data_o    = data_q;
  assign done_timeout_o = timeout_q;

endmodule

`default_nettype wire

// File: mem_bus_timer.sv
// Bus wait timer
// Counts cycles of an unanswered request and flags the timeout
`timescale 1ns/100ps
`default_nettype none

module mem_bus_timer #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic run_i,
  output logic expired_o
);

  localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] count_q;

  // Saturates at the limit until run_i drops
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || !run_i)
      count_q <= '0;
    else if (!expired_o)
      count_q <= count_q + 1'b1;
  end

  assign expired_o = (count_q == CNT_W'(TIMEOUT_CYCLES));

endmodule

`default_nettype wire

// File: mem_pipe.f
mem_pipe_pkg.sv
mem_bus_timer.sv
mem_agen.sv
mem_scratchpad.sv
mem_bus_fsm.sv
mem_result.sv
mem_pipe.sv
tb_clock_gen.sv
tb_mem_pipe.sv

// File: mem_pipe.sv
// Load/store pipeline top
// Agen, local scratchpad, external bus master and result stage
`timescale 1ns/100ps
`default_nettype none

module mem_pipe #(
  parameter int unsigned                    SPAD_WORDS     = 256,
  parameter logic [mem_pipe_pkg::XLEN-1:0] BUS_BASE       = 32'h8000_0000,
  parameter logic [mem_pipe_pkg::XLEN-1:0] BUS_SIZE       = 32'h0000_1000,
  parameter int unsigned                    TIMEOUT_CYCLES = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          dispatch_v_i,
  input  mem_pipe_pkg::mem_dispatch_s   dispatch_i,
  output logic                          ready_o,
  output logic                          result_v_o,
  output mem_pipe_pkg::mem_result_s     result_o,
  output logic                          bus_req_o,
  output logic [mem_pipe_pkg::XLEN-1:0] bus_addr_o,
  output logic                          bus_we_o,
  output logic [3:0]                    bus_be_o,
  output logic [mem_pipe_pkg::XLEN-1:0] bus_wdata_o,
  input  logic                          bus_ack_i,
  input  logic [mem_pipe_pkg::XLEN-1:0] bus_rdata_i
);
  import mem_pipe_pkg::*;

  mem_access_s access;
  mem_word_u   spad_rdata;
  mem_word_u   bus_data;
  logic        stall;
  logic        bus_done;
  logic        bus_timeout;

  mem_agen #(
    .SPAD_WORDS(SPAD_WORDS),
    .BUS_BASE  (BUS_BASE),
    .BUS_SIZE  (BUS_SIZE)
  ) i_agen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dispatch_v_i(dispatch_v_i),
    .dispatch_i  (dispatch_i),
    .stall_i     (stall),
    .access_o    (access)
  );

  mem_scratchpad #(
    .SPAD_WORDS(SPAD_WORDS)
  ) i_scratchpad (
    .clk_i   (clk_i),
    .access_i(access),
    .rdata_o (spad_rdata)
  );

  mem_bus_fsm #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_bus_fsm (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .access_i      (access),
    .bus_ack_i     (bus_ack_i),
    .bus_rdata_i   (bus_rdata_i),
    .bus_req_o     (bus_req_o),
    .bus_addr_o    (bus_addr_o),
    .bus_we_o      (bus_we_o),
    .bus_be_o      (bus_be_o),
    .bus_wdata_o   (bus_wdata_o),
    .stall_o       (stall),
    .ready_o       (ready_o),
    .done_o        (bus_done),
    .done_data_o   (bus_data),
    .done_timeout_o(bus_timeout)
  );

  mem_result i_result (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .access_i     (access),
    .spad_rdata_i (spad_rdata),
    .bus_done_i   (bus_done),
    .bus_data_i   (bus_data),
    .bus_timeout_i(bus_timeout),
    .result_v_o   (result_v_o),
    .result_o     (result_o)
  );

endmodule

`default_nettype wire

// File: mem_pipe_pkg.sv
// Shared types for the load/store pipeline
// Op, region and fault codes, the memory word view and stage packets
`default_nettype none

package mem_pipe_pkg;

  localparam int XLEN = 32;

  typedef enum logic [2:0]
  {
    e_op_lb,
    e_op_lh,
    e_op_lw,
    e_op_lbu,
    e_op_lhu,
    e_op_sb,
    e_op_sh,
    e_op_sw
  } mem_op_e;

  typedef enum logic [1:0]
  {
    e_size_byte,
    e_size_half,
    e_size_word
  } mem_size_e;

  typedef enum logic [1:0]
  {
    e_region_local,
    e_region_bus,
    e_region_unmapped
  } mem_region_e;

  typedef enum logic [1:0]
  {
    e_fault_none,
    e_fault_misaligned,
    e_fault_access
  } mem_fault_e;

  // One memory word, seen as byte lanes or halfword lanes
  typedef union packed
  {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

  typedef struct packed
  {
    mem_op_e         op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs2;
    logic [4:0]      rd;
  } mem_dispatch_s;

  typedef struct packed
  {
    logic            valid;
    mem_op_e         op;
    mem_size_e       size;
    logic [XLEN-1:0] eaddr;
    logic [3:0]      be;
    mem_word_u       wdata;
    logic [4:0]      rd;
    mem_region_e     region;
    mem_fault_e      fault;
  } mem_access_s;

  typedef struct packed
  {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    mem_fault_e      fault;
    logic            is_load;
  } mem_result_s;

  function automatic logic op_is_store(mem_op_e op);
    return op inside {e_op_sb, e_op_sh, e_op_sw};
  endfunction

endpackage

`default_nettype wire

// File: mem_result.sv
// Result stage
// Selects scratchpad or bus data, extends loads and registers the
// result packet with its fault code
`timescale 1ns/100ps
`default_nettype none

module mem_result (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mem_pipe_pkg::mem_access_s access_i,
  input  mem_pipe_pkg::mem_word_u   spad_rdata_i,
  input  logic                      bus_done_i,
  input  mem_pipe_pkg::mem_word_u   bus_data_i,
  input  logic                      bus_timeout_i,
  output logic                      result_v_o,
  output mem_pipe_pkg::mem_result_s result_o
);
  import mem_pipe_pkg::*;

  mem_access_s     local_q;
  logic            local_take;
  mem_access_s     sel;
  mem_word_u       word;
  mem_fault_e      fault;
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;
  logic [XLEN-1:0] data;
  logic            result_v_q;
  mem_result_s     result_q;

  // Everything except a clean bus access follows the scratchpad timing
  assign local_take = access_i.valid
                   && !((access_i.region == e_region_bus)
                        && (access_i.fault == e_fault_none));

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      local_q <= '0;
    else if (local_take)
      local_q <= access_i;
    else
      local_q.valid <= 1'b0;
  end

  always_comb
  begin
    sel   = local_q;
    word  = spad_rdata_i;
    fault = local_q.fault;
    if (bus_done_i)
    begin
      sel   = access_i;
      word  = bus_data_i;
      fault = bus_timeout_i ? e_fault_access : e_fault_none;
    end
    ld_byte = word.bytes[sel.eaddr[1:0]];
    ld_half = word.halves[sel.eaddr[1]];
    case (sel.op)
      e_op_lb:  data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
      e_op_lbu: data = {{(XLEN-8){1'b0}}, ld_byte};
      e_op_lh:  data = {{(XLEN-16){ld_half[15]}}, ld_half};
      e_op_lhu: data = {{(XLEN-16){1'b0}}, ld_half};
      e_op_lw:  data = word;
      default:  data = '0;
    endcase
    if (fault != e_fault_none)
      data = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      result_v_q <= 1'b0;
    else
      result_v_q <= bus_done_i || local_q.valid;
  end

  always_ff @(posedge clk_i)
  begin
    result_q.rd      <= sel.rd;
    result_q.data    <= data;
    result_q.fault   <= fault;
    result_q.is_load <= !op_is_store(sel.op);
  end

  assign result_v_o = result_v_q;
  assign result_o   = result_q;

endmodule

`default_nettype wire

// File: mem_scratchpad.sv
// Local data scratchpad
// Word-addressed RAM with byte-lane writes and a registered read port
`timescale 1ns/100ps
`default_nettype none

module mem_scratchpad #(
  parameter int unsigned SPAD_WORDS = 256
) (
  input  logic                      clk_i,
  input  mem_pipe_pkg::mem_access_s access_i,
  output mem_pipe_pkg::mem_word_u   rdata_o
);
  import mem_pipe_pkg::*;

  localparam int unsigned IDX_W = (SPAD_WORDS > 1) ? $clog2(SPAD_WORDS) : 1;

  mem_word_u        mem_q [SPAD_WORDS];
  mem_word_u        rdata_q;
  logic [IDX_W-1:0] idx;
  logic             wr_en;

  assign idx = access_i.eaddr[IDX_W+1:2];

  // Only clean local stores touch the array
  assign wr_en = access_i.valid
              && (access_i.region == e_region_local)
              && (access_i.fault == e_fault_none)
              && op_is_store(access_i.op);

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (access_i.be[i])
          mem_q[idx].bytes[i] <= access_i.wdata.bytes[i];
      end
    end
    rdata_q <= mem_q[idx];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the load/store pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_pipe -f mem_pipe.f -o sim_mem_pipe \
  > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_mem_pipe > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

// File: tb_clock_gen.sv
// Testbench clock and reset source
// Free-running clock and a synchronous active-low reset pulse
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_mem_pipe.sv
// Testbench for the load/store pipeline
// Table of accesses with expected results, a four-phase bus slave model
// and an in-order result checker
`timescale 1ns/100ps
`default_nettype none

module tb_mem_pipe;
  import mem_pipe_pkg::*;

  localparam int unsigned     SPAD_WORDS     = 256;
  localparam logic [XLEN-1:0] BUS_BASE       = 32'h8000_0000;
  localparam logic [XLEN-1:0] BUS_SIZE       = 32'h0000_1000;
  localparam int unsigned     TIMEOUT_CYCLES = 16;
  localparam int              RESET_CYCLES   = 10;
  localparam int              NUM_ROWS       = 29;

  typedef struct packed
  {
    mem_op_e         op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs2;
    logic            silent;
    logic [XLEN-1:0] exp_data;
    mem_fault_e      exp_fault;
  } row_t;

  logic            clk;
  logic            rst_n;
  logic            dispatch_v;
  mem_dispatch_s   dispatch;
  logic            ready;
  logic            result_v;
  mem_result_s     result;
  logic            bus_req;
  logic [XLEN-1:0] bus_addr;
  logic            bus_we;
  logic [3:0]      bus_be;
  logic [XLEN-1:0] bus_wdata;
  logic            bus_ack;
  logic [XLEN-1:0] bus_rdata;

  row_t            rows [NUM_ROWS];
  logic [XLEN-1:0] bus_mem [logic [XLEN-1:0]];
  int              pend_row [$];
  int              pend_cycle [$];
  int              cycle       = 0;
  int              issue_count = 0;
  int              done_count  = 0;
  logic            bus_busy    = 1'b0;
  logic            bus_silent  = 1'b0;
  logic            req_prev    = 1'b0;
  logic [15:0]     lfsr_q      = 16'd15427;
  int              resp_delay;
  int              resp_hold;
  logic [XLEN-1:0] resp_key;
  logic [XLEN-1:0] resp_word;
  row_t            chk_row;
  int              chk_idx;
  int              chk_t0;

  tb_clock_gen #(
    .PERIOD_NS   (20),
    .RESET_CYCLES(RESET_CYCLES)
  ) i_clock_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  mem_pipe #(
    .SPAD_WORDS    (SPAD_WORDS),
    .BUS_BASE      (BUS_BASE),
    .BUS_SIZE      (BUS_SIZE),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_mem_pipe (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .dispatch_v_i(dispatch_v),
    .dispatch_i  (dispatch),
    .ready_o     (ready),
    .result_v_o  (result_v),
    .result_o    (result),
    .bus_req_o   (bus_req),
    .bus_addr_o  (bus_addr),
    .bus_we_o    (bus_we),
    .bus_be_o    (bus_be),
    .bus_wdata_o (bus_wdata),
    .bus_ack_i   (bus_ack),
    .bus_rdata_i (bus_rdata)
  );

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    stop_on_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    stop_on_failure();
  endtask

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // Clean bus accesses have open latency and all others take two cycles
  function automatic logic on_bus_path(input row_t r);
    logic [XLEN-1:0] eaddr;
    eaddr = r.rs1 + r.imm;
    return (eaddr >= BUS_BASE) && ((eaddr - BUS_BASE) < BUS_SIZE)
        && (r.exp_fault != e_fault_misaligned);
  endfunction

  function automatic logic row_is_load(input row_t r);
    return !(r.op inside {e_op_sb, e_op_sh, e_op_sw});
  endfunction

  initial
  begin
    // Local stores, then every load flavor on the stored bytes
    rows[0]  = '{e_op_sw,  32'h100, 32'h0, 32'h8765_43A1, 1'b0, 32'h0, e_fault_none};
    rows[1]  = '{e_op_sh,  32'h100, 32'h4, 32'h0000_9ABC, 1'b0, 32'h0, e_fault_none};
    rows[2]  = '{e_op_sb,  32'h100, 32'h6, 32'h0000_0080, 1'b0, 32'h0, e_fault_none};
    rows[3]  = '{e_op_sb,  32'h100, 32'h7, 32'h0000_007F, 1'b0, 32'h0, e_fault_none};
    rows[4]  = '{e_op_lw,  32'h100, 32'h0, 32'h0, 1'b0, 32'h8765_43A1, e_fault_none};
    rows[5]  = '{e_op_lb,  32'h100, 32'h0, 32'h0, 1'b0, 32'hFFFF_FFA1, e_fault_none};
    rows[6]  = '{e_op_lbu, 32'h100, 32'h0, 32'h0, 1'b0, 32'h0000_00A1, e_fault_none};
    rows[7]  = '{e_op_lh,  32'h100, 32'h2, 32'h0, 1'b0, 32'hFFFF_8765, e_fault_none};
    rows[8]  = '{e_op_lhu, 32'h100, 32'h2, 32'h0, 1'b0, 32'h0000_8765, e_fault_none};
    rows[9]  = '{e_op_lb,  32'h100, 32'h7, 32'h0, 1'b0, 32'h0000_007F, e_fault_none};
    rows[10] = '{e_op_lb,  32'h100, 32'h6, 32'h0, 1'b0, 32'hFFFF_FF80, e_fault_none};
    rows[11] = '{e_op_lh,  32'h100, 32'h4, 32'h0, 1'b0, 32'hFFFF_9ABC, e_fault_none};
    rows[12] = '{e_op_lw,  32'h100, 32'h4, 32'h0, 1'b0, 32'h7F80_9ABC, e_fault_none};
    // Misaligned accesses leave memory untouched
    rows[13] = '{e_op_sw,  32'h100, 32'h1, 32'hDEAD_BEEF, 1'b0, 32'h0, e_fault_misaligned};
    rows[14] = '{e_op_sh,  32'h100, 32'h3, 32'h0000_1234, 1'b0, 32'h0, e_fault_misaligned};
    rows[15] = '{e_op_lw,  32'h100, 32'h2, 32'h0, 1'b0, 32'h0, e_fault_misaligned};
    rows[16] = '{e_op_lw,  32'h100, 32'h0, 32'h0, 1'b0, 32'h8765_43A1, e_fault_none};
    rows[17] = '{e_op_lw,  32'h4000_0000, 32'h0, 32'h0, 1'b0, 32'h0, e_fault_access};
    rows[18] = '{e_op_sb,  32'h400, 32'h0, 32'h0000_0011, 1'b0, 32'h0, e_fault_access};
    // Bus round trips, a silent slave, then recovery
    rows[19] = '{e_op_sw,  BUS_BASE, 32'h10, 32'hCAFE_F00D, 1'b0, 32'h0, e_fault_none};
    rows[20] = '{e_op_lw,  BUS_BASE, 32'h10, 32'h0, 1'b0, 32'hCAFE_F00D, e_fault_none};
    rows[21] = '{e_op_sb,  BUS_BASE, 32'h13, 32'h0000_0055, 1'b0, 32'h0, e_fault_none};
    rows[22] = '{e_op_lbu, BUS_BASE, 32'h13, 32'h0, 1'b0, 32'h0000_0055, e_fault_none};
    rows[23] = '{e_op_lh,  BUS_BASE, 32'h12, 32'h0, 1'b0, 32'h0000_55FE, e_fault_none};
    rows[24] = '{e_op_lw,  BUS_BASE, 32'h20, 32'h0, 1'b1, 32'h0, e_fault_access};
    rows[25] = '{e_op_lw,  BUS_BASE, 32'h10, 32'h0, 1'b0, 32'h55FE_F00D, e_fault_none};
    rows[26] = '{e_op_lhu, 32'h100, 32'h6, 32'h0, 1'b0, 32'h0000_7F80, e_fault_none};
    rows[27] = '{e_op_lw,  BUS_BASE, BUS_SIZE, 32'h0, 1'b0, 32'h0, e_fault_access};
    rows[28] = '{e_op_lbu, 32'h108, 32'hFFFF_FFFF, 32'h0, 1'b0, 32'h0000_007F, e_fault_none};

    dispatch_v <= 1'b0;
    dispatch   <= '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    assert (ready && !bus_req && !result_v)
    else abort_run("pipe outputs not idle after reset");

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      dispatch_v <= 1'b1;
      dispatch   <= {rows[i].op, rows[i].rs1, rows[i].imm, rows[i].rs2, 5'(i)};
      @(posedge clk);
      while (!ready)
        @(posedge clk);
    end
    dispatch_v <= 1'b0;

    wait (done_count == NUM_ROWS);
    @(posedge clk);
    if ((issue_count == NUM_ROWS) && (pend_row.size() == 0))
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
    begin
      abort_run("accepted accesses and returned results do not match up");
    end
  end

  // Samples pre-edge values of acceptance, bus protocol and results
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (rst_n)
    begin
      if (bus_req && !req_prev)
      begin
        assert (!bus_ack)
        else abort_run("bus_req rose while bus_ack was still high");
      end
      if (bus_busy)
      begin
        assert (!ready)
        else abort_run("ready high before the bus result came out");
      end
      if (dispatch_v && ready)
      begin
        pend_row.push_back(issue_count);
        pend_cycle.push_back(cycle);
        if (on_bus_path(rows[issue_count]))
        begin
          bus_busy   = 1'b1;
          bus_silent = rows[issue_count].silent;
        end
        issue_count = issue_count + 1;
      end
      if (result_v)
      begin
        if (pend_row.size() == 0)
          abort_run("result_v pulsed with no access in flight");
        chk_idx = pend_row.pop_front();
        chk_t0  = pend_cycle.pop_front();
        chk_row = rows[chk_idx];
        assert (result.rd == 5'(chk_idx))
        else report_mismatch("result.rd", 32'(result.rd), 32'(chk_idx));
        assert (result.data == chk_row.exp_data)
        else report_mismatch("result.data", result.data, chk_row.exp_data);
        assert (result.fault == chk_row.exp_fault)
        else report_mismatch("result.fault", 32'(result.fault), 32'(chk_row.exp_fault));
        assert (result.is_load == row_is_load(chk_row))
        else report_mismatch("result.is_load", 32'(result.is_load),
                             32'(row_is_load(chk_row)));
        if (on_bus_path(chk_row))
        begin
          bus_busy = 1'b0;
        end
        else
        begin
          // Valid rises at the second edge after acceptance and is seen at the third
          assert ((cycle - chk_t0) == 3)
          else abort_run("local or faulted result not 2 cycles after acceptance");
        end
        done_count = done_count + 1;
      end
    end
    req_prev = bus_req;
  end

  // Four-phase bus slave with a word-keyed memory
  initial
  begin
    bus_ack   <= 1'b0;
    bus_rdata <= '0;
    forever
    begin
      @(posedge clk);
      if (bus_req && !bus_ack && !bus_silent)
      begin
        lfsr_q     = lfsr_step(lfsr_q);
        resp_delay = 1 + int'(lfsr_q[0]);
        lfsr_q     = lfsr_step(lfsr_q);
        resp_delay = resp_delay + 2 * int'(lfsr_q[0]);
        repeat (resp_delay) @(posedge clk);
        resp_key  = {bus_addr[XLEN-1:2], 2'b00};
        resp_word = bus_mem.exists(resp_key) ? bus_mem[resp_key] : '0;
        if (bus_we)
        begin
          for (int b = 0; b < 4; b++)
          begin
            if (bus_be[b])
              resp_word[8*b +: 8] = bus_wdata[8*b +: 8];
          end
          bus_mem[resp_key] = resp_word;
          bus_rdata <= '0;
        end
        else
        begin
          bus_rdata <= resp_word;
        end
        bus_ack <= 1'b1;
        @(posedge clk);
        while (bus_req)
          @(posedge clk);
        // Ack lingers 4 to 7 cycles after req falls
        resp_hold = 4;
        for (int k = 0; k < 2; k++)
        begin
          lfsr_q    = lfsr_step(lfsr_q);
          resp_hold = resp_hold + (int'(lfsr_q[0]) << k);
        end
        repeat (resp_hold) @(posedge clk);
        bus_ack <= 1'b0;
      end
    end
  end

  initial
  begin
    repeat (RESET_CYCLES + NUM_ROWS * (TIMEOUT_CYCLES + 10)) @(posedge clk);
    abort_run("watchdog expired before all results arrived");
  end

endmodule

`default_nettype wire
